// ==== posit_defs.svh ====
// ****************************************
// Width and depth constants for the posit32 es3 adder
// Include in every file that sizes a posit field
// ****************************************
`ifndef POSIT_DEFS_SVH
`define POSIT_DEFS_SVH

`define POSIT_N 32
`define POSIT_ES 3

// Raw value fields, scale = regime * 8 + exponent
`define SCALE_W 9
`define FRAC_W 26
`define SUM_FRAC_W 28

// Result queue slots, also the credits upstream starts with
`define QUEUE_DEPTH 8

`endif

// ==== posit_pkg.sv ====
// ****************************************
// Types shared by the posit adder blocks
// Raw values between decode, add and encode
// ****************************************
`default_nettype none

`include "posit_defs.svh"

package posit_pkg;

    typedef enum logic {
        op_add = 1'b0,
        op_sub = 1'b1
    } op_e;

    // Decoded operand
    typedef struct packed {
        logic                       sgn;
        logic signed [`SCALE_W-1:0] scale;
        logic [`FRAC_W-1:0]         fraction;   // Hidden bit not stored
        logic                       nar;
        logic                       zero;
    } raw_value_t;

    // Normalized sum, two guard bits below the fraction
    typedef struct packed {
        logic                       sgn;
        logic signed [`SCALE_W-1:0] scale;
        logic [`SUM_FRAC_W-1:0]     fraction;
        logic                       nar;
        logic                       zero;
    } raw_sum_t;

    typedef struct packed {
        op_e                 op;
        logic [`POSIT_N-1:0] a;
        logic [`POSIT_N-1:0] b;
    } add_req_t;

    typedef struct packed {
        logic [`POSIT_N-1:0] result;
        logic                inexact;
    } add_rsp_t;

endpackage

`default_nettype wire

// ==== posit_decode.sv ====
// ****************************************
// Posit word to raw value, one register stage
// negate flips the sign for subtraction
// ****************************************
`timescale 1ns/100ps
`default_nettype none

`include "posit_defs.svh"

module posit_decode (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       valid_in,
    input  wire [`POSIT_N-1:0]        word,
    input  wire                       negate,
    output logic                      valid_out,
    output posit_pkg::raw_value_t     value
);
    import posit_pkg::*;

    localparam int BODY_W = `POSIT_N - 1;
    localparam int CNT_W  = $clog2(`POSIT_N);
    localparam int REG_W  = `SCALE_W - `POSIT_ES;

    logic [`POSIT_N-1:0] mag;
    logic [BODY_W-1:0]   body;
    logic [BODY_W-1:0]   run_bits;
    logic [CNT_W-1:0]    run_len;
    logic [REG_W-1:0]    regime;
    logic [BODY_W-1:0]   rest;
    raw_value_t          dec;

    always_comb
    begin
        mag      = word[`POSIT_N-1] ? (~word + 1'b1) : word;   // Two's complement of negatives
        body     = mag[BODY_W-1:0];
        run_bits = body[BODY_W-1] ? ~body : body;               // Regime run becomes leading zeros
        run_len  = CNT_W'(BODY_W);
        for (int i = 0; i < BODY_W; i++)
        begin
            if (run_bits[i])
                run_len = CNT_W'(BODY_W - 1 - i);
        end
        regime = body[BODY_W-1] ? REG_W'(run_len - 1'b1) : -{1'b0, run_len};
        rest   = body << ({1'b0, run_len} + 1'b1);              // Drop run and terminating bit

        dec.zero     = word == '0;
        dec.nar      = word == {1'b1, {BODY_W{1'b0}}};
        dec.sgn      = word[`POSIT_N-1] ^ negate;
        dec.scale    = {regime, rest[BODY_W-1 -: `POSIT_ES]};  // regime * 8 + exponent
        dec.fraction = rest[BODY_W-1-`POSIT_ES -: `FRAC_W];
        if (dec.zero || dec.nar)
        begin
            dec.sgn      = 1'b0;
            dec.scale    = '0;
            dec.fraction = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        value <= dec;
    end

endmodule

`default_nettype wire

// ==== posit_raw_add.sv ====
// ****************************************
// Four stage adder on raw posit values
// Accepts one operand pair per cycle, done 4 cycles after start
// ****************************************
`timescale 1ns/100ps
`default_nettype none

`include "posit_defs.svh"

module posit_raw_add (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start,
    input  wire posit_pkg::raw_value_t a,
    input  wire posit_pkg::raw_value_t b,
    output logic                      done,
    output posit_pkg::raw_sum_t       sum,
    output logic                      truncated
);
    import posit_pkg::*;

    localparam int GUARD_W = `SUM_FRAC_W - `FRAC_W;
    localparam int ALN_W   = `SUM_FRAC_W + 1;   // Hidden bit, fraction and guard bits
    localparam int SUM_W   = ALN_W + 1;         // Carry on top
    localparam int SHF_W   = 2 * ALN_W;         // Room for the bits shifted out
    localparam int POS_W   = $clog2(SUM_W);

    logic [3:0]          stage_vld;

    raw_value_t          r0_a, r0_b;
    logic                r0_a_ge_b;
    raw_value_t          r0_hi, r0_lo;
    logic                r0_add;
    logic [`SCALE_W-1:0] r0_diff;

    raw_value_t          r1_hi, r1_lo;
    logic                r1_add;
    logic [`SCALE_W-1:0] r1_diff;
    logic [ALN_W-1:0]    r1_hi_m, r1_lo_m;
    logic [SHF_W-1:0]    r1_lo_shf;
    logic                r1_lost;
    logic [SUM_W-1:0]    r1_sum_raw;

    logic                r2_sgn, r2_lost, r2_nar;
    logic [`SCALE_W-1:0] r2_scale, r2_scale_adj;
    logic [SUM_W-1:0]    r2_sum_raw;
    logic [POS_W-1:0]    r2_lead, r2_lz;

    logic                r3_sgn, r3_lost, r3_nar, r3_zero;
    logic [`SCALE_W-1:0] r3_scale;
    logic [SUM_W-1:0]    r3_sum_raw, r3_norm;
    logic [POS_W-1:0]    r3_lz;

    always_ff @(posedge clk)
    begin
        if (rst)
            stage_vld <= '0;
        else
            stage_vld <= {stage_vld[2:0], start};
    end

    // Order by magnitude; flipping the scale sign bit makes it compare unsigned
    always_comb
    begin
        r0_a_ge_b = r0_b.zero | (~r0_a.zero &
                    ({~r0_a.scale[`SCALE_W-1], r0_a.scale[`SCALE_W-2:0], r0_a.fraction} >=
                     {~r0_b.scale[`SCALE_W-1], r0_b.scale[`SCALE_W-2:0], r0_b.fraction}));
        r0_hi   = r0_a_ge_b ? r0_a : r0_b;
        r0_lo   = r0_a_ge_b ? r0_b : r0_a;
        r0_add  = r0_hi.sgn == r0_lo.sgn;   // Equal signs add
        r0_diff = r0_hi.scale - r0_lo.scale;
    end

    // Align the smaller operand and add
    always_comb
    begin
        r1_hi_m    = {~r1_hi.zero, r1_hi.fraction, {GUARD_W{1'b0}}};
        r1_lo_shf  = {~r1_lo.zero, r1_lo.fraction, {(SHF_W - `FRAC_W - 1){1'b0}}} >> r1_diff;
        r1_lo_m    = r1_lo_shf[SHF_W-1 -: ALN_W];
        // A shift past the whole window drops every bit of a nonzero operand
        r1_lost    = (|r1_lo_shf[SHF_W-ALN_W-1:0]) | (~r1_lo.zero & (r1_diff >= SHF_W));
        if (r1_add)
            r1_sum_raw = SUM_W'(r1_hi_m) + SUM_W'(r1_lo_m);
        else
            r1_sum_raw = SUM_W'(r1_hi_m) - SUM_W'(r1_lo_m) - SUM_W'(r1_lost); // Lost bits borrow
    end

    // Leading one detection
    always_comb
    begin
        r2_lead = '0;
        for (int i = 0; i < SUM_W; i++)
        begin
            if (r2_sum_raw[i])
                r2_lead = POS_W'(i);
        end
        r2_lz        = POS_W'(SUM_W - 1) - r2_lead;
        r2_scale_adj = r2_scale + `SCALE_W'(r2_lead) - `SCALE_W'(ALN_W - 1);
    end

    always_ff @(posedge clk)
    begin
        r0_a       <= a;
        r0_b       <= b;
        r1_hi      <= r0_hi;
        r1_lo      <= r0_lo;
        r1_add     <= r0_add;
        r1_diff    <= r0_diff;
        r2_sgn     <= r1_hi.sgn;
        r2_scale   <= r1_hi.scale;
        r2_sum_raw <= r1_sum_raw;
        r2_lost    <= r1_lost;
        r2_nar     <= r1_hi.nar | r1_lo.nar;
        r3_sgn     <= r2_sgn;
        r3_scale   <= r2_scale_adj;
        r3_sum_raw <= r2_sum_raw;
        r3_lz      <= r2_lz;
        r3_lost    <= r2_lost;
        r3_nar     <= r2_nar;
        r3_zero    <= r2_sum_raw == '0;     // Also exact cancellation
    end

    // Normalize so the leading one sits at the top
    always_comb
    begin
        r3_norm      = r3_sum_raw << r3_lz;
        sum.sgn      = r3_sgn;
        sum.scale    = r3_scale;
        sum.fraction = r3_norm[SUM_W-2 -: `SUM_FRAC_W];
        sum.nar      = r3_nar;
        sum.zero     = ~r3_nar & r3_zero;
    end

    assign truncated = r3_lost | r3_norm[0];
    assign done      = stage_vld[3];

endmodule

`default_nettype wire

// ==== posit_encode.sv ====
// ****************************************
// Raw sum to posit word with round to nearest even
// Clamps to maxpos and minpos, one register stage
// ****************************************
`timescale 1ns/100ps
`default_nettype none

`include "posit_defs.svh"

module posit_encode (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     valid_in,
    input  wire posit_pkg::raw_sum_t sum,
    input  wire                     truncated,
    output logic                    valid_out,
    output posit_pkg::add_rsp_t     rsp
);
    import posit_pkg::*;

    localparam int BODY_W    = `POSIT_N - 1;
    localparam int EXT_W     = 2 * BODY_W;
    localparam int REG_W     = `SCALE_W - `POSIT_ES;
    localparam int MAX_SCALE = (`POSIT_N - 2) * (1 << `POSIT_ES);

    logic [REG_W-1:0]  k;
    logic              k_neg;
    logic [REG_W-2:0]  rs;
    logic [EXT_W-1:0]  ext, shifted;
    logic [BODY_W-1:0] body, body_fin;
    logic              round_bit, sticky, round_up;
    add_rsp_t          rsp_d;

    always_comb
    begin
        k     = sum.scale[`SCALE_W-1:`POSIT_ES];
        k_neg = k[REG_W-1];
        rs    = k_neg ? ~k[REG_W-2:0] : k[REG_W-2:0];   // -k-1 zeros after the pattern, or k ones
        // Regime seed 10 or 01 grows by sign fill
        ext       = {~k_neg, k_neg, sum.scale[`POSIT_ES-1:0], sum.fraction,
                     {(EXT_W - 2 - `POSIT_ES - `SUM_FRAC_W){1'b0}}};
        shifted   = $signed(ext) >>> rs;
        body      = shifted[EXT_W-1 -: BODY_W];
        round_bit = shifted[EXT_W-BODY_W-1];
        sticky    = (|shifted[EXT_W-BODY_W-2:0]) | truncated;
        round_up  = round_bit & (sticky | body[0]);

        body_fin      = body + BODY_W'(round_up);
        rsp_d.inexact = round_bit | sticky;
        if (sum.scale >= MAX_SCALE)
        begin
            body_fin      = '1;     // maxpos
            rsp_d.inexact = (sum.scale != MAX_SCALE) | (|sum.fraction) | truncated;
        end
        else if (sum.scale < -MAX_SCALE)
        begin
            body_fin      = BODY_W'(1);     // minpos
            rsp_d.inexact = 1'b1;
        end

        rsp_d.result = sum.sgn ? -{1'b0, body_fin} : {1'b0, body_fin};
        if (sum.nar)
        begin
            rsp_d.result  = {1'b1, {BODY_W{1'b0}}};
            rsp_d.inexact = 1'b0;
        end
        else if (sum.zero)
        begin
            rsp_d.result  = '0;
            rsp_d.inexact = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_out <= 1'b0;
        else
            valid_out <= valid_in;
    end

    always_ff @(posedge clk)
    begin
        rsp <= rsp_d;
    end

endmodule

`default_nettype wire

// ==== posit_result_queue.sv ====
// ****************************************
// Result FIFO, released only against downstream credits
// Each pop hands one credit back upstream
// ****************************************
`timescale 1ns/100ps
`default_nettype none

`include "posit_defs.svh"

module posit_result_queue (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     push,
    input  wire posit_pkg::add_rsp_t push_data,
    input  wire                     out_credit,
    output logic                    out_valid,
    output posit_pkg::add_rsp_t     out_rsp,
    output logic                    in_credit
);
    import posit_pkg::*;

    localparam int ADDR_W   = $clog2(`QUEUE_DEPTH);
    localparam int CREDIT_W = 8;

    add_rsp_t            mem [`QUEUE_DEPTH];
    logic [ADDR_W-1:0]   wr_ptr, rd_ptr;
    logic [ADDR_W:0]     count;
    logic [CREDIT_W-1:0] credits;  // Downstream slots known free
    logic                pop;

    assign pop       = (count != '0) && (credits != '0);
    assign out_valid = pop;
    assign out_rsp   = mem[rd_ptr];
    assign in_credit = pop;         // Freed slot goes back upstream

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == ADDR_W'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == ADDR_W'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count   <= count + (ADDR_W+1)'(push) - (ADDR_W+1)'(pop);
            credits <= credits + CREDIT_W'(out_credit) - CREDIT_W'(pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    // Upstream credits must keep pipeline plus queue within the queue size
    a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> count != (ADDR_W+1)'(`QUEUE_DEPTH));

    // Downstream never returns more credits than the counter can hold
    a_credit_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (out_credit && !pop) |-> credits != '1);

endmodule

`default_nettype wire

// ==== posit_add_unit.sv ====
// ****************************************
// Posit32 es3 add/sub unit with credit flow control
// ****************************************
`timescale 1ns/100ps
`default_nettype none

module posit_add_unit (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    input  wire posit_pkg::add_req_t in_req,
    output logic                    in_credit,
    output logic                    out_valid,
    output posit_pkg::add_rsp_t     out_rsp,
    input  wire                     out_credit
);
    import posit_pkg::*;

    logic       a_valid, b_valid;
    raw_value_t a_raw, b_raw;
    logic       sum_done, sum_truncated;
    raw_sum_t   sum_raw;
    logic       enc_valid;
    add_rsp_t   enc_rsp;

    posit_decode dec_a (
        .clk(clk), .rst(rst), .valid_in(in_valid), .word(in_req.a),
        .negate(1'b0), .valid_out(a_valid), .value(a_raw)
    );

    // Subtraction flips the second operand
    posit_decode dec_b (
        .clk(clk), .rst(rst), .valid_in(in_valid), .word(in_req.b),
        .negate(in_req.op == op_sub), .valid_out(b_valid), .value(b_raw)
    );

    posit_raw_add adder (
        .clk(clk), .rst(rst), .start(a_valid & b_valid), .a(a_raw), .b(b_raw),
        .done(sum_done), .sum(sum_raw), .truncated(sum_truncated)
    );

    posit_encode encoder (
        .clk(clk), .rst(rst), .valid_in(sum_done), .sum(sum_raw),
        .truncated(sum_truncated), .valid_out(enc_valid), .rsp(enc_rsp)
    );

    posit_result_queue queue (
        .clk(clk), .rst(rst), .push(enc_valid), .push_data(enc_rsp),
        .out_credit(out_credit), .out_valid(out_valid), .out_rsp(out_rsp),
        .in_credit(in_credit)
    );

endmodule

`default_nettype wire

// ==== tb_posit_add_unit.sv ====
// ****************************************
// Self-checking testbench for the posit add unit
// Vectors come from posit_add_tests.txt
// ****************************************
`timescale 1ns/100ps
`default_nettype none

`include "posit_defs.svh"

module tb_posit_add_unit;
    import posit_pkg::*;

    localparam int MAX_VECTORS  = 64;
    localparam int IDLE_CYCLES  = 8;    // Quiet time after reset, credits only
    localparam int HOLD_PERIOD  = 40;   // Length of each credit window
    localparam int MAX_OUTSTAND = 4;

    logic     clk;
    logic     rst;
    logic     in_valid;
    add_req_t in_req;
    logic     in_credit;
    logic     out_valid;
    add_rsp_t out_rsp;
    logic     out_credit;

    logic                vec_op     [MAX_VECTORS];
    logic [`POSIT_N-1:0] vec_a      [MAX_VECTORS];
    logic [`POSIT_N-1:0] vec_b      [MAX_VECTORS];
    logic [`POSIT_N-1:0] vec_result [MAX_VECTORS];
    logic                vec_inexact[MAX_VECTORS];

    int     num_vectors;
    int     sent;
    int     received;
    int     returned;       // Downstream credits handed to the DUT
    int     freed;          // in_credit pulses seen
    int     up_credits;
    int     cycles;
    int     timeout_limit;
    logic   withhold;
    integer seed;

    posit_add_unit UUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_req(in_req),
        .in_credit(in_credit), .out_valid(out_valid), .out_rsp(out_rsp),
        .out_credit(out_credit)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t ns: %s mismatch, got %h expected %h",
                     $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic load_vectors;
        integer      fd;
        integer      n;
        string       line;
        logic [31:0] op, a, b, res, inx;
        fd = $fopen("posit_add_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file posit_add_tests.txt");
            $display("TESTS FAILED");
            $fatal(1, "No vectors");
        end
        else
        begin
            num_vectors = 0;
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h", op, a, b, res, inx);
                if (n == 5 && num_vectors < MAX_VECTORS)     // Comment lines give 0
                begin
                    vec_op[num_vectors]      = op[0];
                    vec_a[num_vectors]       = a;
                    vec_b[num_vectors]       = b;
                    vec_result[num_vectors]  = res;
                    vec_inexact[num_vectors] = inx[0];
                    num_vectors++;
                end
            end
            $fclose(fd);
            if (num_vectors == 0)
            begin
                $display("The vector file holds no usable lines");
                $display("TESTS FAILED");
                $fatal(1, "No vectors");
            end
        end
    endtask

    initial
    begin
        seed       = 32'h97c190eb;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_req     = '0;
        out_credit = 1'b0;
        sent       = 0;
        received   = 0;
        returned   = 0;
        freed      = 0;
        up_credits = `QUEUE_DEPTH;
        cycles     = 0;
        load_vectors();
        timeout_limit = 20 * num_vectors + 100;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        while (received < num_vectors)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_limit)
            begin
                $display("Timeout after %0d cycles with %0d of %0d results delivered",
                         cycles, received, num_vectors);
                $display("TESTS FAILED");
                $fatal(1, "Timeout");
            end
            else
            begin
                // Outputs seen here belong to the cycle that just ended
                if (sent == 0)
                begin
                    check_value(out_valid, 1'b0, "out_valid before any request");
                    check_value(in_credit, 1'b0, "in_credit before any request");
                end
                if (out_valid)
                begin
                    check_value({out_rsp.result, out_rsp.inexact},
                                {vec_result[received], vec_inexact[received]},
                                $sformatf("response of vector %0d", received));
                    received++;
                end
                if (in_credit)
                begin
                    freed++;
                    up_credits++;
                end
                check_value(received <= returned, 1'b1, "results within returned credits");
                check_value(freed, received, "in_credit pulses against results");

                // One request per cycle while a credit is held
                if (sent < num_vectors && up_credits > 0 && cycles > IDLE_CYCLES)
                begin
                    in_valid  <= 1'b1;
                    in_req.op <= vec_op[sent] ? op_sub : op_add;
                    in_req.a  <= vec_a[sent];
                    in_req.b  <= vec_b[sent];
                    up_credits--;
                    sent++;
                end
                else
                    in_valid <= 1'b0;

                // Credits are withheld every other window
                withhold = ((cycles / HOLD_PERIOD) % 2) == 1;
                if (!withhold && (returned - received) < MAX_OUTSTAND && $random(seed) % 2 != 0)
                begin
                    out_credit <= 1'b1;
                    returned++;
                end
                else
                    out_credit <= 1'b0;
            end
        end

        // Spare credits must not pull out any further result
        in_valid   <= 1'b0;
        out_credit <= 1'b1;
        repeat (IDLE_CYCLES)
        begin
            @(posedge clk);
            check_value(out_valid, 1'b0, "out_valid after the last result");
            check_value(in_credit, 1'b0, "in_credit after the last result");
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== posit_add_unit.f ====
+incdir+.
posit_pkg.sv
posit_decode.sv
posit_raw_add.sv
posit_encode.sv
posit_result_queue.sv
posit_add_unit.sv
tb_posit_add_unit.sv

// ==== posit_add_tests.txt ====
// Each line holds op a b result inexact in hex
// op 0 adds and op 1 subtracts b from a
0 40000000 40000000 44000000 0
0 40000000 44000000 46000000 0
0 40000000 3C000000 42000000 0
0 40000000 38000000 41000000 0
0 60000000 40000000 60020000 0
0 44000000 38000000 44800000 0
0 BA000000 C0000000 B8000000 0
1 46000000 40000000 44000000 0
1 48000000 46000000 40000000 0
1 40000000 40000000 00000000 0
0 40000000 BC000000 C0000000 0
1 40000000 C0000000 44000000 0
1 3C000000 40000000 C4000000 0
0 00000000 40000000 40000000 0
0 46000000 00000000 46000000 0
0 80000000 40000000 80000000 0
1 40000000 80000000 80000000 0
0 40000000 06800000 40000000 1
0 40000001 06800000 40000002 1
0 40000000 06C00000 40000001 1
0 40000000 06000000 40000000 1
0 40000000 02000000 40000000 1
0 60000000 0F800000 60000002 1
0 7FFFFFFF 7FFFFFFF 7FFFFFFF 1
0 80000001 80000001 80000001 1
